/* rtl/intt_pkg.sv */
/* constants, twiddle table and types for a 16-point inverse NTT over q = 97 with two lanes.
   the twiddle table only holds for these values, so ring size and lane count are not free */
package intt_pkg;

    // ring and field
    localparam int RING_SIZE  = 16;   // coefficients per polynomial
    localparam int RING_DEPTH = 4;    // log2(RING_SIZE), number of butterfly stages
    localparam int LANE_COUNT = 2;    // butterfly lanes working side by side
    localparam int DATA_W     = 7;    // wide enough for 0..96
    localparam int ADDR_W     = 4;    // 16 coefficient slots

    localparam int Q = 97;            // modulus

    // lane pipeline depth, issue to write-back request
    localparam int LANE_LATENCY = 3;

    // cycles of issue per stage, each lane takes one butterfly per cycle
    localparam int ISSUE_CYCLES = RING_SIZE / (2 * LANE_COUNT);

    typedef logic [DATA_W-1:0] coef_t;
    typedef logic [ADDR_W-1:0] addr_t;

    localparam coef_t N_INV = 7'd91;  // 16 * 91 = 1 mod 97

    // powers of 85 mod 97, 85 being the inverse of the 16th root 8
    localparam coef_t INV_TWIDDLE [RING_SIZE/2] = '{
        7'd1,  7'd85, 7'd47, 7'd18,
        7'd75, 7'd70, 7'd33, 7'd89
    };

    typedef enum logic {
        op_butterfly,                 // x = a + b, y = (a - b) * w
        op_scale                      // x = a * w, y = b * w
    } lane_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,                      // serial load, one coefficient per cycle
        st_stage,                     // butterfly issue
        st_drain,                     // wait for lane write-back
        st_scale,                     // n_inv pass issue
        st_finish,                    // done pulse
        st_read                       // serial readout
    } seq_state_t;

    // one lane operation, operands already fetched
    typedef struct packed {
        logic     valid;
        lane_op_t op;
        coef_t    a;
        coef_t    b;
        coef_t    w;
        addr_t    addr_a;
        addr_t    addr_b;
    } lane_req_t;

    // lane result with its write-back addresses
    typedef struct packed {
        logic  valid;
        coef_t x;
        coef_t y;
        addr_t addr_a;
        addr_t addr_b;
    } lane_rsp_t;

endpackage

/* rtl/butterfly_lane.sv */
/* three-stage modular butterfly / scale lane, accepts one request every cycle.
   operands must already be reduced below q */
module butterfly_lane (
    input  logic                clk,
    input  logic                reset,
    input  intt_pkg::lane_req_t req,
    output intt_pkg::lane_rsp_t rsp
);
    import intt_pkg::*;

    typedef logic [DATA_W:0]     wide_t;   // room for a + b and a + q - b
    typedef logic [2*DATA_W-1:0] prod_t;   // full product

    wide_t    sum;
    coef_t    add_mod;
    coef_t    sub_mod;

    logic     s1_valid;
    lane_op_t s1_op;
    coef_t    s1_x, s1_y, s1_w;
    addr_t    s1_addr_a, s1_addr_b;

    logic     s2_valid;
    prod_t    s2_px, s2_py;
    addr_t    s2_addr_a, s2_addr_b;

    logic     rsp_valid;
    coef_t    rsp_x, rsp_y;
    addr_t    rsp_addr_a, rsp_addr_b;

    // modular add and subtract, one correction each
    assign sum     = wide_t'(req.a) + wide_t'(req.b);
    assign add_mod = (sum >= wide_t'(Q)) ? coef_t'(sum - wide_t'(Q)) : coef_t'(sum);
    assign sub_mod = (req.a >= req.b) ? req.a - req.b
                                      : coef_t'(wide_t'(req.a) + wide_t'(Q) - wide_t'(req.b));

    // valid chain
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= req.valid;
            s2_valid  <= s1_valid;
            rsp_valid <= s2_valid;
        end
    end

    // data path
    always_ff @(posedge clk) begin
        // stage 1, add/sub or pass through for a scale
        s1_op     <= req.op;
        s1_x      <= (req.op == op_scale) ? req.a : add_mod;
        s1_y      <= (req.op == op_scale) ? req.b : sub_mod;
        s1_w      <= req.w;
        s1_addr_a <= req.addr_a;
        s1_addr_b <= req.addr_b;
        // stage 2, the sum only gets w in a scale
        s2_px     <= prod_t'(s1_x) * prod_t'((s1_op == op_scale) ? s1_w : coef_t'(1));
        s2_py     <= prod_t'(s1_y) * prod_t'(s1_w);
        s2_addr_a <= s1_addr_a;
        s2_addr_b <= s1_addr_b;
        // stage 3, reduce by the constant modulus
        rsp_x      <= coef_t'(s2_px % prod_t'(Q));
        rsp_y      <= coef_t'(s2_py % prod_t'(Q));
        rsp_addr_a <= s2_addr_a;
        rsp_addr_b <= s2_addr_b;
    end

    assign rsp = '{
        valid:  rsp_valid,
        x:      rsp_x,
        y:      rsp_y,
        addr_a: rsp_addr_a,
        addr_b: rsp_addr_b
    };

endmodule

/* rtl/coef_store.sv */
/* 16-entry coefficient register file, combinational lane reads, registered readout.
   load and lane write-back addresses must never collide, the sequencer keeps them apart */
module coef_store (
    input  logic                clk,
    input  logic                reset,
    // serial load
    input  logic                load_en,
    input  intt_pkg::addr_t     load_addr,
    input  intt_pkg::coef_t     din,
    // lane operand reads
    input  intt_pkg::addr_t     rd_addr_a [intt_pkg::LANE_COUNT],
    input  intt_pkg::addr_t     rd_addr_b [intt_pkg::LANE_COUNT],
    output intt_pkg::coef_t     rd_data_a [intt_pkg::LANE_COUNT],
    output intt_pkg::coef_t     rd_data_b [intt_pkg::LANE_COUNT],
    // lane write-back
    input  intt_pkg::lane_rsp_t rsp       [intt_pkg::LANE_COUNT],
    // serial readout
    input  logic                read_en,
    input  intt_pkg::addr_t     read_addr,
    output intt_pkg::coef_t     dout
);
    import intt_pkg::*;

    coef_t mem [RING_SIZE];                     // the polynomial

    // writes from load and from every lane
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < RING_SIZE; i++) begin
                mem[i] <= '0;                   // contents start at zero
            end
        end else begin
            if (load_en) begin
                mem[load_addr] <= din;          // natural order
            end
            for (int l = 0; l < LANE_COUNT; l++) begin
                if (rsp[l].valid) begin
                    mem[rsp[l].addr_a] <= rsp[l].x;
                    mem[rsp[l].addr_b] <= rsp[l].y;
                end
            end
        end
    end

    // operand reads, same cycle as the address
    always_comb begin
        for (int l = 0; l < LANE_COUNT; l++) begin
            rd_data_a[l] = mem[rd_addr_a[l]];
            rd_data_b[l] = mem[rd_addr_b[l]];
        end
    end

    // readout register, gives the 2-cycle offset from read_out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (read_en) begin
            dout <= mem[read_addr];
        end else begin
            dout <= '0;                         // quiet outside readout
        end
    end

endmodule

/* rtl/intt_sequencer.sv */
/* schedules load, 4 butterfly stages, the n_inv pass and readout.
   commands are only taken in st_idle, priority read_out, load_data, start_intt */
module intt_sequencer (
    input  logic                clk,
    input  logic                reset,
    // host commands
    input  logic                load_data,
    input  logic                start_intt,
    input  logic                read_out,
    // operand fetch
    output intt_pkg::addr_t     rd_addr_a [intt_pkg::LANE_COUNT],
    output intt_pkg::addr_t     rd_addr_b [intt_pkg::LANE_COUNT],
    input  intt_pkg::coef_t     rd_data_a [intt_pkg::LANE_COUNT],
    input  intt_pkg::coef_t     rd_data_b [intt_pkg::LANE_COUNT],
    // lane issue
    output intt_pkg::lane_req_t lane_req  [intt_pkg::LANE_COUNT],
    // store control
    output logic                load_en,
    output intt_pkg::addr_t     load_addr,
    output logic                read_en,
    output intt_pkg::addr_t     read_addr,
    output logic                done
);
    import intt_pkg::*;

    seq_state_t state;

    logic [$clog2(RING_DEPTH+1)-1:0]   stage_cnt;  // RING_DEPTH marks the scale pass
    logic [$clog2(ISSUE_CYCLES)-1:0]   issue_cnt;  // issue cycle within a stage
    logic [$clog2(LANE_LATENCY+1)-1:0] drain_cnt;
    addr_t                             xfer_cnt;   // load and readout address

    logic [$clog2(RING_DEPTH)-1:0] stage_lo;       // stage number for shifts
    logic                          issuing;
    lane_op_t                      issue_op;
    coef_t                         issue_w [LANE_COUNT];

    assign stage_lo = stage_cnt[$clog2(RING_DEPTH)-1:0];
    assign issuing  = (state == st_stage) || (state == st_scale);
    assign issue_op = (state == st_scale) ? op_scale : op_butterfly;

    // main FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= st_idle;
            stage_cnt <= '0;
            issue_cnt <= '0;
            drain_cnt <= '0;
            xfer_cnt  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    stage_cnt <= '0;
                    issue_cnt <= '0;
                    xfer_cnt  <= '0;
                    if (read_out) begin
                        state <= st_read;
                    end else if (load_data) begin
                        state <= st_load;
                    end else if (start_intt) begin
                        state <= st_stage;      // stage 0 first
                    end
                end
                st_load, st_read: begin
                    xfer_cnt <= xfer_cnt + 1'b1;
                    if (xfer_cnt == addr_t'(RING_SIZE - 1)) begin
                        state <= st_idle;       // all 16 moved
                    end
                end
                st_stage, st_scale: begin
                    issue_cnt <= issue_cnt + 1'b1;  // wraps to 0 for the next stage
                    drain_cnt <= '0;
                    if (issue_cnt == ISSUE_CYCLES - 1) begin
                        state <= st_drain;
                    end
                end
                st_drain: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    // last write-back lands before the next stage reads
                    if (drain_cnt == LANE_LATENCY) begin
                        stage_cnt <= stage_cnt + 1'b1;
                        if (stage_cnt == RING_DEPTH) begin
                            state <= st_finish;      // scale pass written
                        end else if (stage_cnt == RING_DEPTH - 1) begin
                            state <= st_scale;
                        end else begin
                            state <= st_stage;
                        end
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // pair addresses and twiddles, butterfly index = issue_cnt * LANE_COUNT + lane
    always_comb begin : addr_gen
        addr_t                idx;
        addr_t                half;
        addr_t                pos;
        addr_t                base;
        logic  [ADDR_W-2:0]   tw_idx;
        half = addr_t'(RING_SIZE / 2) >> stage_lo;    // distance 8, 4, 2, 1
        for (int l = 0; l < LANE_COUNT; l++) begin
            idx    = addr_t'(issue_cnt) * addr_t'(LANE_COUNT) + addr_t'(l);
            pos    = idx & (half - 1'b1);             // position inside the block
            base   = ((idx - pos) << 1) | pos;        // block start is twice the block index
            tw_idx = pos[ADDR_W-2:0] << stage_lo;     // w^(pos * 2^s), always below 8
            if (state == st_scale) begin
                rd_addr_a[l] = idx << 1;              // consecutive pairs
                rd_addr_b[l] = (idx << 1) | addr_t'(1);
                issue_w[l]   = N_INV;
            end else begin
                rd_addr_a[l] = base;
                rd_addr_b[l] = base + half;
                issue_w[l]   = INV_TWIDDLE[tw_idx];
            end
        end
    end

    // requests leave one cycle after the operand read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                lane_req[l] <= '0;
            end
        end else begin
            for (int l = 0; l < LANE_COUNT; l++) begin
                lane_req[l].valid  <= issuing;
                lane_req[l].op     <= issue_op;
                lane_req[l].a      <= rd_data_a[l];
                lane_req[l].b      <= rd_data_b[l];
                lane_req[l].w      <= issue_w[l];
                lane_req[l].addr_a <= rd_addr_a[l];
                lane_req[l].addr_b <= rd_addr_b[l];
            end
        end
    end

    // store control decodes
    assign load_en   = (state == st_load);
    assign load_addr = xfer_cnt;
    assign read_en   = (state == st_read);
    assign read_addr = xfer_cnt;
    assign done      = (state == st_finish);     // one cycle, after the last scaled write

endmodule

/* rtl/intt_core.sv */
/* 16-point INTT over q = 97: serial load, run with done pulse, serial bit-reversed readout.
   pulse commands only while idle, others are dropped */
module intt_core (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_data,     // then 16 cycles of din
    input  logic            start_intt,
    input  logic            read_out,      // dout valid 2 cycles later for 16 cycles
    input  intt_pkg::coef_t din,
    output logic            done,
    output intt_pkg::coef_t dout
);
    import intt_pkg::*;

    addr_t     rd_addr_a [LANE_COUNT];
    addr_t     rd_addr_b [LANE_COUNT];
    coef_t     rd_data_a [LANE_COUNT];
    coef_t     rd_data_b [LANE_COUNT];
    lane_req_t lane_req  [LANE_COUNT];     // sequencer to lanes
    lane_rsp_t lane_rsp  [LANE_COUNT];     // lanes to store

    logic      load_en;
    addr_t     load_addr;
    logic      read_en;
    addr_t     read_addr;

    intt_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .load_data  (load_data),
        .start_intt (start_intt),
        .read_out   (read_out),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .lane_req   (lane_req),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .read_en    (read_en),
        .read_addr  (read_addr),
        .done       (done)
    );

    // identical lanes
    for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
        butterfly_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .req   (lane_req[l]),
            .rsp   (lane_rsp[l])
        );
    end

    coef_store u_store (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .din       (din),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .rsp       (lane_rsp),
        .read_en   (read_en),
        .read_addr (read_addr),
        .dout      (dout)
    );

endmodule

/* test/intt_sva.sv */
/* control-output assertions, bound into intt_core.
   the dout range check assumes the host only loads coefficients below q */
module intt_sva (
    input logic                clk,
    input logic                reset,
    input logic                done,
    input intt_pkg::coef_t     dout,
    input intt_pkg::lane_req_t lane_req [intt_pkg::LANE_COUNT]
);
    import intt_pkg::*;

    int fail_cnt = 0;                      // failed assertions so far

    // done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done high on two consecutive cycles");
        end

    // readout stays inside the field
    dout_in_field: assert property (@(posedge clk) disable iff (reset)
        dout < coef_t'(Q))
        else begin
            fail_cnt++;
            $error("dout %0d not below q", dout);
        end

    // no lane traffic right after the run ends
    for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane_quiet
        req_idle_after_done: assert property (@(posedge clk) disable iff (reset)
            done |=> !lane_req[l].valid)
            else begin
                fail_cnt++;
                $error("lane %0d request valid in the cycle after done", l);
            end
    end

endmodule

bind intt_core intt_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .done     (done),
    .dout     (dout),
    .lane_req (lane_req)
);

/* test/intt_tb.sv */
/* testbench for intt_core: loads each table vector, runs the INTT and checks the readout
   against a direct O(n^2) inverse transform in bit-reversed order */
module intt_tb;
    import intt_pkg::*;

    localparam int NUM_VECTORS    = 6;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS * 120 + RESET_CYCLES;  // about 90 used per vector
    localparam int ROOT           = 8;     // primitive 16th root of unity mod 97
    localparam int READ_WINDOW    = 20;    // cycles watched after read_out
    localparam int IDLE_CYCLES    = 20;

    typedef coef_t vec_t [RING_SIZE];

    logic  clk;
    logic  reset;
    logic  load_data;
    logic  start_intt;
    logic  read_out;
    coef_t din;
    logic  done;
    coef_t dout;

    vec_t  stim_tab [NUM_VECTORS];         // input vectors
    vec_t  exp_tab  [NUM_VECTORS];         // readout order, bit-reversed
    int    seed;
    int    value_errors;
    int    pulse_errors;
    int    cycle_cnt;

    intt_core DUT (
        .clk        (clk),
        .reset      (reset),
        .load_data  (load_data),
        .start_intt (start_intt),
        .read_out   (read_out),
        .din        (din),
        .done       (done),
        .dout       (dout)
    );

    always #50 clk = ~clk;                 // period 100

    function automatic int mod_pow(int base, int e);
        int r;
        r = 1;
        for (int i = 0; i < e; i++) begin
            r = (r * base) % Q;
        end
        return r;
    endfunction

    // inverse by search over the field
    function automatic int mod_inverse(int v);
        for (int x = 1; x < Q; x++) begin
            if ((v * x) % Q == 1) begin
                return x;
            end
        end
        return 0;
    endfunction

    function automatic int bit_reverse(int k);
        int r;
        r = 0;
        for (int b = 0; b < RING_DEPTH; b++) begin
            r = (r << 1) | ((k >> b) & 1);
        end
        return r;
    endfunction

    // A[j] = n^-1 * sum in[i] * root^-(i*j), then scrambled into readout order
    task automatic compute_expected(input vec_t vin, output vec_t vout);
        int inv_root;
        int n_inv;
        int acc;
        int a_nat [RING_SIZE];
        inv_root = mod_inverse(ROOT);                  // 85
        n_inv    = mod_inverse(RING_SIZE % Q);          // 91
        for (int j = 0; j < RING_SIZE; j++) begin
            acc = 0;
            for (int i = 0; i < RING_SIZE; i++) begin
                acc = (acc + int'(vin[i]) * mod_pow(inv_root, (i * j) % RING_SIZE)) % Q;
            end
            a_nat[j] = (acc * n_inv) % Q;
        end
        for (int k = 0; k < RING_SIZE; k++) begin
            vout[k] = coef_t'(a_nat[bit_reverse(k)]);
        end
    endtask

    task automatic build_table();
        int r;
        seed = 21;
        for (int i = 0; i < RING_SIZE; i++) begin
            stim_tab[0][i] = '0;
            stim_tab[1][i] = (i == 0) ? coef_t'(1) : '0;     // impulse at 0
            stim_tab[2][i] = (i == 5) ? coef_t'(1) : '0;     // impulse at 5
            stim_tab[3][i] = coef_t'(96);                     // q - 1 everywhere
            exp_tab[0][i]  = '0;
            exp_tab[1][i]  = coef_t'(91);                     // flat spectrum times n_inv
        end
        for (int e = 4; e < NUM_VECTORS; e++) begin
            for (int i = 0; i < RING_SIZE; i++) begin
                r = $random(seed);
                stim_tab[e][i] = coef_t'(((r % Q) + Q) % Q);  // $random can be negative
            end
        end
        for (int e = 2; e < NUM_VECTORS; e++) begin
            compute_expected(stim_tab[e], exp_tab[e]);
        end
    endtask

    task automatic check_coef(input coef_t actual, input coef_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s, dout %0d, expected %0d", $time, what, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_pulse(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s, done %b, expected %b", $time, what, actual, expected);
            pulse_errors++;
        end
    endtask

    // one closing line with the counts, then the verdict
    task automatic finish_run(input logic timed_out);
        int sva_errors;
        sva_errors = DUT.u_sva.fail_cnt;
        $display("summary: %0d value errors, %0d pulse errors, %0d assertion failures",
                 value_errors, pulse_errors, sva_errors);
        if (!timed_out && value_errors == 0 && pulse_errors == 0 && sva_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // pulse at the current falling edge, din follows on the next 16
    task automatic load_vector(input vec_t v);
        load_data = 1'b1;
        for (int i = 0; i < RING_SIZE; i++) begin
            @(negedge clk);
            load_data = 1'b0;
            din       = v[i];
            check_pulse(done, 1'b0, "done during load");
        end
        @(negedge clk);
        din = '0;
    endtask

    // pulse start, then wait for done
    task automatic run_transform();
        start_intt = 1'b1;
        do begin
            @(negedge clk);
            start_intt = 1'b0;
        end while (done !== 1'b1);
        repeat (3) begin
            @(negedge clk);
            check_pulse(done, 1'b0, "done longer than one cycle");
        end
    endtask

    // values in cycles 2..17, zero elsewhere; optional commands thrown in mid-readout
    task automatic read_and_check(input vec_t expv, input logic disturb, input int entry);
        read_out = 1'b1;
        for (int c = 1; c <= READ_WINDOW; c++) begin
            @(negedge clk);
            read_out = 1'b0;
            if (disturb) begin
                start_intt = (c == 5);          // must be dropped, not idle
                load_data  = (c == 9);
            end
            check_pulse(done, 1'b0, "done during readout");
            if (c >= 2 && c <= RING_SIZE + 1) begin
                check_coef(dout, expv[c-2], $sformatf("vector %0d position %0d", entry, c - 2));
            end else begin
                check_coef(dout, '0, $sformatf("vector %0d quiet cycle %0d", entry, c));
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        load_data    = 1'b0;
        start_intt   = 1'b0;
        read_out     = 1'b0;
        din          = '0;
        value_errors = 0;
        pulse_errors = 0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        // nothing commanded, outputs stay quiet
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_pulse(done, 1'b0, "done while idle");
            check_coef(dout, '0, "dout while idle");
        end
        for (int e = 0; e < NUM_VECTORS; e++) begin
            load_vector(stim_tab[e]);
            run_transform();
            read_and_check(exp_tab[e], e >= 4, e);
        end
        finish_run(1'b0);
    end

    // watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: done never arrived");
        finish_run(1'b1);
    end

endmodule

/* all.f */
rtl/intt_pkg.sv
rtl/butterfly_lane.sv
rtl/coef_store.sv
rtl/intt_sequencer.sv
rtl/intt_core.sv
test/intt_sva.sv
test/intt_tb.sv
